/* opc_pkg.sv */
//////////////////////////////
// Sizes and enums shared by the operand collection stage.
// Modules refer to them by scoped name
//////////////////////////////

package opc_pkg;

    // Lanes per warp and number of warps
    localparam int NUM_THREADS = 2;
    localparam int NUM_WARPS   = 4;
    localparam int WID_BITS    = 2;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_BITS = 5;

    // Opcodes are carried through the stage unchanged
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_mul    = 4'd2,
        op_fma    = 4'd3,
        op_load   = 4'd4,
        op_store  = 4'd5,
        op_branch = 4'd6
    } op_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_fetch1 = 2'd1,
        st_fetch2 = 2'd2,
        st_fetch3 = 2'd3
    } fetch_state_t;

    // Staging buffer payload: warp id, thread mask, opcode, rd, immediate
    localparam int META_BITS = WID_BITS + NUM_THREADS + $bits(op_t) + REG_BITS + XLEN;

endpackage

/* gpr_bank.sv */
//////////////////////////////
// Register storage of one thread lane for all warps.
// Synchronous write, combinational read
//////////////////////////////

`timescale 1ns/10ps

module gpr_bank (
    input  logic                                            clk,
    input  logic                                            we,
    input  logic [opc_pkg::WID_BITS+opc_pkg::REG_BITS-1:0]  waddr,
    input  logic [opc_pkg::XLEN-1:0]                        wdata,
    input  logic [opc_pkg::WID_BITS+opc_pkg::REG_BITS-1:0]  raddr,
    output logic [opc_pkg::XLEN-1:0]                        rdata
);

    localparam int DEPTH = opc_pkg::NUM_WARPS * opc_pkg::NUM_REGS;

    // Address is the warp id in the upper bits and the register number below
    logic [opc_pkg::XLEN-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

    // A writeback must never land on an unknown address
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("gpr_bank write with unknown address");

endmodule

/* skid_buffer.sv */
//////////////////////////////
// Valid/ready FIFO of DEPTH registered entries.
// Used as the staging buffer and the output buffer
//////////////////////////////

`timescale 1ns/10ps

module skid_buffer #(
    parameter int DATAW = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             ready_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW = $clog2(DEPTH + 1);

    logic [DATAW-1:0] mem [DEPTH];
    logic [PTRW-1:0]  rd_ptr;
    logic [PTRW-1:0]  wr_ptr;
    logic [CNTW-1:0]  count;
    logic             push;
    logic             pop;

    assign valid_out = (count != '0);
    // A full buffer still takes an item in the cycle one leaves
    assign ready_in  = (count != CNTW'(DEPTH)) || ready_out;
    assign push      = valid_in && ready_in;
    assign pop       = valid_out && ready_out;
    assign data_out  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNTW'(push) - CNTW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (valid_out && !ready_out) |=> $stable(data_out)
    ) else $error("skid_buffer output changed while stalled");

endmodule

/* wb_cache.sv */
//////////////////////////////
// Last-writeback cache, one entry per warp.
// Looked up by warp id and gives the tag, lanes and data
//////////////////////////////

`timescale 1ns/10ps

module wb_cache (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       flush,
    input  logic                                       wb_valid,
    input  logic [opc_pkg::WID_BITS-1:0]               wb_wid,
    input  logic [opc_pkg::REG_BITS-1:0]               wb_rd,
    input  logic [opc_pkg::NUM_THREADS-1:0]            wb_tmask,
    input  logic                                       wb_sop,
    input  logic                                       wb_eop,
    input  logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] wb_data,
    input  logic [opc_pkg::WID_BITS-1:0]               rd_wid,
    output logic [opc_pkg::REG_BITS-1:0]               rd_reg,
    output logic [opc_pkg::NUM_THREADS-1:0]            rd_tmask,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] rd_data
);

    localparam int XLEN = opc_pkg::XLEN;

    logic [opc_pkg::REG_BITS-1:0]            cache_reg   [opc_pkg::NUM_WARPS];
    logic [opc_pkg::NUM_THREADS-1:0]         cache_tmask [opc_pkg::NUM_WARPS];
    logic [opc_pkg::NUM_THREADS*XLEN-1:0]    cache_data  [opc_pkg::NUM_WARPS];
    logic [opc_pkg::NUM_WARPS-1:0]           cache_eop;
    logic                                    take;

    // Same register again, or a new packet after the last one closed
    assign take = wb_valid &&
                  ((cache_reg[wb_wid] == wb_rd) || (cache_eop[wb_wid] && wb_sop));

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int w = 0; w < opc_pkg::NUM_WARPS; w++) begin
                cache_reg[w]   <= '0;
                cache_tmask[w] <= '0;
            end
            cache_eop <= '1;
        end else if (take) begin
            cache_reg[wb_wid] <= wb_rd;
            cache_eop[wb_wid] <= wb_eop;
            if (wb_sop) begin
                cache_tmask[wb_wid] <= wb_tmask;
            end else begin
                cache_tmask[wb_wid] <= cache_tmask[wb_wid] | wb_tmask;
            end
        end
    end

    // Only the masked lanes are overwritten
    always_ff @(posedge clk) begin
        if (take) begin
            for (int j = 0; j < opc_pkg::NUM_THREADS; j++) begin
                if (wb_tmask[j]) begin
                    cache_data[wb_wid][j*XLEN +: XLEN] <= wb_data[j*XLEN +: XLEN];
                end
            end
        end
    end

    assign rd_reg   = cache_reg[rd_wid];
    assign rd_tmask = cache_tmask[rd_wid];
    assign rd_data  = cache_data[rd_wid];

endmodule

/* operand_fetch.sv */
//////////////////////////////
// Operand fetch FSM. Resolves each source to zero, a cache
// hit or a bank read and holds the gathered operands
// until the staging buffer hands its bundle on
//////////////////////////////

`timescale 1ns/10ps

module operand_fetch (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          flush,
    input  logic                                          in_valid,
    input  logic                                          in_ready,
    input  logic [opc_pkg::WID_BITS-1:0]                  in_wid,
    input  logic [opc_pkg::NUM_THREADS-1:0]               in_tmask,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rs1,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rs2,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rs3,
    input  logic [opc_pkg::REG_BITS-1:0]                  cache_reg,
    input  logic [opc_pkg::NUM_THREADS-1:0]               cache_tmask,
    input  logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] cache_data,
    input  logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] bank_rdata,
    input  logic                                          stg_valid,
    input  logic                                          stg_ready_out,
    output logic [opc_pkg::WID_BITS-1:0]                  cache_wid,
    output logic [opc_pkg::WID_BITS+opc_pkg::REG_BITS-1:0] bank_raddr,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] rs1_data,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] rs2_data,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] rs3_data,
    output logic                                          data_ready
);

    localparam int DW = opc_pkg::NUM_THREADS * opc_pkg::XLEN;

    opc_pkg::fetch_state_t          state, state_n;
    logic [opc_pkg::WID_BITS-1:0]   rd_wid, rd_wid_n;
    logic [opc_pkg::REG_BITS-1:0]   rd_rid, rd_rid_n;
    logic [opc_pkg::REG_BITS-1:0]   rs2, rs2_n;
    logic [opc_pkg::REG_BITS-1:0]   rs3, rs3_n;
    logic                           rs2_pend, rs2_pend_n;
    logic                           rs3_pend, rs3_pend_n;
    logic [DW-1:0]                  rs1_data_n, rs2_data_n, rs3_data_n;
    logic                           data_ready_n;
    logic                           issue;
    logic                           rs1_zero, rs2_zero, rs3_zero;
    logic                           rs1_ok, rs2_ok, rs3_ok;
    logic                           lanes_cached;

    assign issue     = in_valid && in_ready;
    assign cache_wid = in_wid;
    assign bank_raddr = {rd_wid, rd_rid};

    // The cached entry only helps if it covers every issuing lane
    assign lanes_cached = ((in_tmask & cache_tmask) == in_tmask);
    assign rs1_zero = (in_rs1 == '0);
    assign rs2_zero = (in_rs2 == '0);
    assign rs3_zero = (in_rs3 == '0);
    assign rs1_ok   = rs1_zero || (lanes_cached && in_rs1 == cache_reg);
    assign rs2_ok   = rs2_zero || (lanes_cached && in_rs2 == cache_reg);
    assign rs3_ok   = rs3_zero || (lanes_cached && in_rs3 == cache_reg);

    always_comb begin
        state_n      = state;
        rd_wid_n     = rd_wid;
        rd_rid_n     = rd_rid;
        rs2_n        = rs2;
        rs3_n        = rs3;
        rs2_pend_n   = rs2_pend;
        rs3_pend_n   = rs3_pend;
        rs1_data_n   = rs1_data;
        rs2_data_n   = rs2_data;
        rs3_data_n   = rs3_data;
        data_ready_n = data_ready;

        case (state)
            opc_pkg::st_idle: begin
                if (stg_valid && stg_ready_out) begin
                    data_ready_n = 1'b0;
                end
                if (issue) begin
                    rd_wid_n   = in_wid;
                    rs2_n      = in_rs2;
                    rs3_n      = in_rs3;
                    rs2_pend_n = !rs2_ok;
                    rs3_pend_n = !rs3_ok;
                    rs1_data_n = rs1_zero ? '0 : cache_data;
                    rs2_data_n = rs2_zero ? '0 : cache_data;
                    rs3_data_n = rs3_zero ? '0 : cache_data;
                    // First pending source decides where the walk starts
                    if (!rs1_ok) begin
                        rd_rid_n = in_rs1;
                        state_n  = opc_pkg::st_fetch1;
                    end else if (!rs2_ok) begin
                        rd_rid_n = in_rs2;
                        state_n  = opc_pkg::st_fetch2;
                    end else if (!rs3_ok) begin
                        rd_rid_n = in_rs3;
                        state_n  = opc_pkg::st_fetch3;
                    end else begin
                        data_ready_n = 1'b1;
                    end
                end
            end
            opc_pkg::st_fetch1: begin
                rs1_data_n = bank_rdata;
                if (rs2_pend) begin
                    rd_rid_n = rs2;
                    state_n  = opc_pkg::st_fetch2;
                end else if (rs3_pend) begin
                    rd_rid_n = rs3;
                    state_n  = opc_pkg::st_fetch3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = opc_pkg::st_idle;
                end
            end
            opc_pkg::st_fetch2: begin
                rs2_data_n = bank_rdata;
                if (rs3_pend) begin
                    rd_rid_n = rs3;
                    state_n  = opc_pkg::st_fetch3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = opc_pkg::st_idle;
                end
            end
            default: begin
                rs3_data_n   = bank_rdata;
                data_ready_n = 1'b1;
                state_n      = opc_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state      <= opc_pkg::st_idle;
            rd_wid     <= '0;
            rd_rid     <= '0;
            rs2_pend   <= 1'b0;
            rs3_pend   <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            state      <= state_n;
            rd_wid     <= rd_wid_n;
            rd_rid     <= rd_rid_n;
            rs2_pend   <= rs2_pend_n;
            rs3_pend   <= rs3_pend_n;
            data_ready <= data_ready_n;
        end
    end

    always_ff @(posedge clk) begin
        rs2      <= rs2_n;
        rs3      <= rs3_n;
        rs1_data <= rs1_data_n;
        rs2_data <= rs2_data_n;
        rs3_data <= rs3_data_n;
    end

    // The staging buffer must hold off issue while a bank walk is running
    a_no_issue_busy: assert property (
        @(posedge clk) disable iff (reset || flush)
        issue |-> (data_ready || state == opc_pkg::st_idle)
    ) else $error("operand_fetch took an issue during a fetch");

endmodule

/* operand_unit.sv */
//////////////////////////////
// Operand collection stage top. Register banks, writeback
// cache, fetch FSM, staging and output buffers
//////////////////////////////

`timescale 1ns/10ps

module operand_unit (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          flush,
    input  logic                                          wb_valid,
    input  logic [opc_pkg::WID_BITS-1:0]                  wb_wid,
    input  logic [opc_pkg::REG_BITS-1:0]                  wb_rd,
    input  logic [opc_pkg::NUM_THREADS-1:0]               wb_tmask,
    input  logic                                          wb_sop,
    input  logic                                          wb_eop,
    input  logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] wb_data,
    input  logic                                          in_valid,
    output logic                                          in_ready,
    input  logic [opc_pkg::WID_BITS-1:0]                  in_wid,
    input  logic [opc_pkg::NUM_THREADS-1:0]               in_tmask,
    input  opc_pkg::op_t                                  in_op,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rs1,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rs2,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rs3,
    input  logic [opc_pkg::REG_BITS-1:0]                  in_rd,
    input  logic [opc_pkg::XLEN-1:0]                      in_imm,
    output logic                                          out_valid,
    input  logic                                          out_ready,
    output logic [opc_pkg::WID_BITS-1:0]                  out_wid,
    output logic [opc_pkg::NUM_THREADS-1:0]               out_tmask,
    output opc_pkg::op_t                                  out_op,
    output logic [opc_pkg::REG_BITS-1:0]                  out_rd,
    output logic [opc_pkg::XLEN-1:0]                      out_imm,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] out_rs1_data,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] out_rs2_data,
    output logic [opc_pkg::NUM_THREADS*opc_pkg::XLEN-1:0] out_rs3_data
);

    localparam int XLEN = opc_pkg::XLEN;
    localparam int DW   = opc_pkg::NUM_THREADS * XLEN;
    localparam int OUTW = opc_pkg::META_BITS + 3 * DW;

    logic [opc_pkg::WID_BITS+opc_pkg::REG_BITS-1:0] bank_raddr;
    logic [DW-1:0]                     bank_rdata;
    logic [opc_pkg::WID_BITS-1:0]      cache_wid;
    logic [opc_pkg::REG_BITS-1:0]      cache_reg;
    logic [opc_pkg::NUM_THREADS-1:0]   cache_tmask;
    logic [DW-1:0]                     cache_data;
    logic [DW-1:0]                     rs1_data, rs2_data, rs3_data;
    logic                              data_ready;
    logic                              stg_valid, stg_ready_out;
    logic [opc_pkg::META_BITS-1:0]     stg_meta;
    logic                              outb_valid_in, outb_ready_in;
    logic [3:0]                        out_op_bits;

    for (genvar i = 0; i < opc_pkg::NUM_THREADS; i++) begin : g_bank
        gpr_bank bank_i (
            .clk   (clk),
            .we    (wb_valid && wb_tmask[i]),
            .waddr ({wb_wid, wb_rd}),
            .wdata (wb_data[i*XLEN +: XLEN]),
            .raddr (bank_raddr),
            .rdata (bank_rdata[i*XLEN +: XLEN])
        );
    end

    wb_cache cache_i (
        .clk (clk), .reset (reset), .flush (flush),
        .wb_valid (wb_valid), .wb_wid (wb_wid), .wb_rd (wb_rd),
        .wb_tmask (wb_tmask), .wb_sop (wb_sop), .wb_eop (wb_eop), .wb_data (wb_data),
        .rd_wid (cache_wid), .rd_reg (cache_reg), .rd_tmask (cache_tmask),
        .rd_data (cache_data)
    );

    operand_fetch fetch_i (
        .clk (clk), .reset (reset), .flush (flush),
        .in_valid (in_valid), .in_ready (in_ready), .in_wid (in_wid), .in_tmask (in_tmask),
        .in_rs1 (in_rs1), .in_rs2 (in_rs2), .in_rs3 (in_rs3),
        .cache_reg (cache_reg), .cache_tmask (cache_tmask), .cache_data (cache_data),
        .bank_rdata (bank_rdata), .stg_valid (stg_valid), .stg_ready_out (stg_ready_out),
        .cache_wid (cache_wid), .bank_raddr (bank_raddr),
        .rs1_data (rs1_data), .rs2_data (rs2_data), .rs3_data (rs3_data),
        .data_ready (data_ready)
    );

    skid_buffer #(.DATAW (opc_pkg::META_BITS), .DEPTH (1)) stg_buf_i (
        .clk (clk), .reset (reset || flush),
        .valid_in (in_valid), .data_in ({in_wid, in_tmask, in_op, in_rd, in_imm}),
        .ready_in (in_ready),
        .valid_out (stg_valid), .data_out (stg_meta), .ready_out (stg_ready_out)
    );

    // A bundle moves on only once all its operands are held
    assign outb_valid_in = stg_valid && data_ready;
    assign stg_ready_out = outb_ready_in && data_ready;

    skid_buffer #(.DATAW (OUTW), .DEPTH (2)) out_buf_i (
        .clk (clk), .reset (reset || flush),
        .valid_in (outb_valid_in), .data_in ({stg_meta, rs1_data, rs2_data, rs3_data}),
        .ready_in (outb_ready_in),
        .valid_out (out_valid), .ready_out (out_ready),
        .data_out ({out_wid, out_tmask, out_op_bits, out_rd, out_imm,
                    out_rs1_data, out_rs2_data, out_rs3_data})
    );

    assign out_op = opc_pkg::op_t'(out_op_bits);

endmodule

/* tb_operand_unit.sv */
//////////////////////////////
// Testbench for operand_unit. Runs the commands of
// operand_vectors.txt and checks every output bundle
//////////////////////////////

`timescale 1ns/10ps

module tb_operand_unit;

    logic         clk = 0, reset = 1, flush = 0;
    logic         wb_valid = 0, wb_sop = 0, wb_eop = 0;
    logic [1:0]   wb_wid = 0, wb_tmask = 0, in_wid = 0, in_tmask = 0;
    logic [4:0]   wb_rd = 0, in_rs1 = 0, in_rs2 = 0, in_rs3 = 0, in_rd = 0;
    logic [63:0]  wb_data = 0;
    logic         in_valid = 0, in_ready, out_valid, out_ready = 0;
    opc_pkg::op_t in_op = opc_pkg::op_add;
    logic [31:0]  in_imm = 0;
    logic [1:0]   out_wid, out_tmask;
    opc_pkg::op_t out_op;
    logic [4:0]   out_rd;
    logic [31:0]  out_imm;
    logic [63:0]  out_rs1_data, out_rs2_data, out_rs3_data;

    // Expected bundles in issue order
    logic [1:0]   q_wid[$];
    logic [1:0]   q_tmask[$];
    logic [3:0]   q_op[$];
    logic [4:0]   q_rd[$];
    logic [31:0]  q_imm[$];
    logic [63:0]  q_rs1[$], q_rs2[$], q_rs3[$];

    string        lines[$];
    string        cur_test = "reset";
    int           n_lines = 0, test_errs = 0, n_pass = 0, n_fail = 0;
    bit           stall_mode = 0, hold_low = 0;
    logic [31:0]  rng = 32'd11;

    operand_unit dut_i (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(negedge clk) begin
        rng = xorshift32(rng);
        out_ready <= hold_low ? 1'b0 : (stall_mode ? rng[7] : 1'b1);
    end

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            $display("%s: a vector line has %0d fields instead of %0d", cur_test, got, want);
            test_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (q_wid.size() == 0) begin
                $display("%s: a bundle came out that was never expected", cur_test);
                test_errs++;
            end else begin
                check_val("wid", 64'(q_wid.pop_front()), 64'(out_wid));
                check_val("tmask", 64'(q_tmask.pop_front()), 64'(out_tmask));
                check_val("op", 64'(q_op.pop_front()), 64'(out_op));
                check_val("rd", 64'(q_rd.pop_front()), 64'(out_rd));
                check_val("imm", 64'(q_imm.pop_front()), 64'(out_imm));
                check_val("rs1", q_rs1.pop_front(), out_rs1_data);
                check_val("rs2", q_rs2.pop_front(), out_rs2_data);
                check_val("rs3", q_rs3.pop_front(), out_rs3_data);
            end
        end
    end

    task automatic clear_expected();
        q_wid.delete();
        q_tmask.delete();
        q_op.delete();
        q_rd.delete();
        q_imm.delete();
        q_rs1.delete();
        q_rs2.delete();
        q_rs3.delete();
    endtask

    // Waits until every issued bundle has come out
    task automatic drain();
        int waited;
        waited = 0;
        while (q_wid.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (q_wid.size() != 0) begin
            $display("%s: %0d bundles never arrived", cur_test, q_wid.size());
            test_errs++;
            clear_expected();
        end
    endtask

    task automatic close_test();
        drain();
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", cur_test, test_errs);
            n_fail++;
        end
        test_errs = 0;
    endtask

    task automatic write_back(input logic [31:0] f[7]);
        drain();
        wb_valid = 1;
        wb_wid   = f[0][1:0];
        wb_rd    = f[1][4:0];
        wb_tmask = f[2][1:0];
        wb_sop   = f[3][0];
        wb_eop   = f[4][0];
        wb_data  = {f[6], f[5]};
        @(negedge clk);
        wb_valid = 0;
    endtask

    task automatic issue(input logic [31:0] f[14]);
        int waited;
        waited   = 0;
        in_valid = 1;
        in_wid   = f[0][1:0];
        in_tmask = f[1][1:0];
        in_op    = opc_pkg::op_t'(f[2][3:0]);
        in_rs1   = f[3][4:0];
        in_rs2   = f[4][4:0];
        in_rs3   = f[5][4:0];
        in_rd    = f[6][4:0];
        in_imm   = f[7];
        forever begin
            @(posedge clk);
            if (in_ready) break;
            waited++;
            if (waited > 200) begin
                $display("%s: an issue was never accepted", cur_test);
                test_errs++;
                break;
            end
        end
        if (waited <= 200) begin
            q_wid.push_back(f[0][1:0]);
            q_tmask.push_back(f[1][1:0]);
            q_op.push_back(f[2][3:0]);
            q_rd.push_back(f[6][4:0]);
            q_imm.push_back(f[7]);
            q_rs1.push_back({f[9], f[8]});
            q_rs2.push_back({f[11], f[10]});
            q_rs3.push_back({f[13], f[12]});
        end
        @(negedge clk);
        in_valid = 0;
    endtask

    task automatic do_flush();
        hold_low = 1;
        @(negedge clk);
        flush = 1;
        @(negedge clk);
        flush = 0;
        clear_expected();
        check_val("out_valid", 64'd0, 64'(out_valid));
        hold_low = 0;
    endtask

    initial begin
        int          fd, stall, n;
        string       line, name;
        byte         cmd;
        logic [31:0] wf[7];
        logic [31:0] f[14];
        reset = 1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 0;
        @(negedge clk);
        check_val("out_valid", 64'd0, 64'(out_valid));
        check_val("in_ready", 64'd1, 64'(in_ready));
        close_test();
        fd = $fopen("operand_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open operand_vectors.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                lines.push_back(line);
            end
            $fclose(fd);
            n_lines = lines.size();
            foreach (lines[i]) begin
                line = lines[i];
                cmd = (line.len() > 0) ? line[0] : "#";
                if (cmd == "T") begin
                    if (cur_test != "reset") close_test();
                    n = $sscanf(line, "T %s %d", name, stall);
                    cur_test   = name;
                    stall_mode = (stall != 0);
                    check_fields(n, 2);
                end else if (cmd == "W") begin
                    n = $sscanf(line, "W %h %h %h %h %h %h %h", wf[0], wf[1], wf[2], wf[3],
                                wf[4], wf[5], wf[6]);
                    check_fields(n, 7);
                    write_back(wf);
                end else if (cmd == "I") begin
                    n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13]);
                    check_fields(n, 14);
                    issue(f);
                end else if (cmd == "F") begin
                    do_flush();
                end
            end
            close_test();
            $display("tests passed: %0d failed: %0d", n_pass, n_fail);
            if (n_fail == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of vector lines
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200 + 50) @(posedge clk);
        $display("timeout: the run did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* compile.f */
opc_pkg.sv
gpr_bank.sv
skid_buffer.sv
wb_cache.sv
operand_fetch.sv
operand_unit.sv
tb_operand_unit.sv

/* run.sh */
#!/bin/bash
# Builds the operand unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_operand_unit -o sim_operand_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_operand_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* operand_vectors.txt */
# W warp reg mask sop eop lane0 lane1
# I warp mask op rs1 rs2 rs3 rd imm rs1_l0 rs1_l1 rs2_l0 rs2_l1 rs3_l0 rs3_l1
# T name stall, F flush; all numbers hex
T zero_reg 0
W 0 01 3 1 1 aaaa0001 aaaa0002
I 0 3 0 00 00 00 02 00000010 0 0 0 0 0 0
I 0 3 1 00 01 00 03 00000011 0 0 aaaa0001 aaaa0002 0 0
W 0 00 3 1 1 deadbeef deadbeef
I 0 3 2 00 00 00 04 00000012 0 0 0 0 0 0
I 0 3 3 01 00 00 04 00000013 aaaa0001 aaaa0002 0 0 0 0
T wb_read 0
W 1 05 3 1 1 11110000 11110001
W 1 06 3 1 1 22220000 22220001
W 1 07 3 1 1 33330000 33330001
I 1 3 3 05 06 07 08 00000100 11110000 11110001 22220000 22220001 33330000 33330001
W 2 05 3 1 1 44440000 44440001
W 2 09 3 1 1 55550000 55550001
I 2 3 0 05 05 05 0a 00000101 44440000 44440001 44440000 44440001 44440000 44440001
I 1 3 1 06 06 00 0b 00000102 22220000 22220001 22220000 22220001 0 0
W 1 06 1 1 1 66660000 00000000
I 1 3 4 06 05 07 0c 00000103 66660000 22220001 11110000 11110001 33330000 33330001
W 3 01 3 1 1 77770000 77770001
W 3 01 2 1 1 00000000 88880001
I 3 3 5 01 00 01 0d 00000104 77770000 88880001 0 0 77770000 88880001
T packet 0
W 0 0a 1 1 0 abcd0000 00000000
W 0 0a 2 0 1 00000000 abcd0001
I 0 3 0 0a 0a 00 0e 00000200 abcd0000 abcd0001 abcd0000 abcd0001 0 0
W 0 0b 3 1 1 12340000 12340001
I 0 3 1 0a 0b 0a 0f 00000201 abcd0000 abcd0001 12340000 12340001 abcd0000 abcd0001
T stall_run 1
I 0 3 0 01 0a 0b 10 00000300 aaaa0001 aaaa0002 abcd0000 abcd0001 12340000 12340001
I 1 3 1 05 06 07 11 00000301 11110000 11110001 66660000 22220001 33330000 33330001
I 2 3 2 09 05 00 12 00000302 55550000 55550001 44440000 44440001 0 0
I 3 3 3 01 01 01 13 00000303 77770000 88880001 77770000 88880001 77770000 88880001
I 0 3 4 0b 0b 0b 14 00000304 12340000 12340001 12340000 12340001 12340000 12340001
I 1 3 5 07 00 05 15 00000305 33330000 33330001 0 0 11110000 11110001
I 2 3 6 00 09 09 16 00000306 0 0 55550000 55550001 55550000 55550001
I 0 3 0 0a 01 00 17 00000307 abcd0000 abcd0001 aaaa0001 aaaa0002 0 0
I 3 3 1 00 00 01 18 00000308 0 0 0 0 77770000 88880001
I 1 3 2 06 06 06 19 00000309 66660000 22220001 66660000 22220001 66660000 22220001
I 2 3 3 05 09 05 1a 0000030a 44440000 44440001 55550000 55550001 44440000 44440001
I 0 3 4 01 0b 0a 1b 0000030b aaaa0001 aaaa0002 12340000 12340001 abcd0000 abcd0001
T flush 1
I 1 3 0 05 06 07 20 00000400 11110000 11110001 66660000 22220001 33330000 33330001
I 2 3 1 05 09 00 21 00000401 44440000 44440001 55550000 55550001 0 0
I 3 3 2 01 00 00 22 00000402 77770000 88880001 0 0 0 0
F
I 0 3 3 0a 0b 01 23 00000403 abcd0000 abcd0001 12340000 12340001 aaaa0001 aaaa0002
I 2 3 4 09 00 00 24 00000404 55550000 55550001 0 0 0 0
I 1 3 5 07 07 00 25 00000405 33330000 33330001 33330000 33330001 0 0
